// ==== Makefile ====
SIM       = verilator
TOP       = serial_link_tb
FILELIST  = serial_link_top.f
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUN_FLAGS = +verilator+error+limit+1000
BUILD     = obj_dir
LOG       = sim.log

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/bit_timer.sv ====
`timescale 1ns/1ns

module bit_timer #(
    parameter timing_pkg::tick_cnt_t BIT_CLKS = 8'd8
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    input  logic half,
    output logic tick
);
    localparam timing_pkg::tick_cnt_t LAST = BIT_CLKS - timing_pkg::tick_cnt_t'(1);
    localparam timing_pkg::tick_cnt_t MID  = BIT_CLKS >> 1;

    timing_pkg::tick_cnt_t cnt;

    // a restart with half set starts midway, so the first tick lands
    // in the middle of the bit instead of at its end
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= half ? MID : '0;
        end else if (cnt == LAST) begin
            cnt <= '0;  // wrap at the end of the period
        end else begin
            cnt <= cnt + timing_pkg::tick_cnt_t'(1);
        end
    end

    assign tick = (cnt == LAST);  // one cycle wide, once per period

endmodule

// ==== hw/link_pkg.sv ====
package link_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // payload and frame shape
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0] byte_t;

    // start bit, eight data bits sent msb first, one stop bit
    localparam int unsigned FRAME_BITS = 10;

    localparam logic LINE_IDLE = 1'b1;  // the stop bit shares this level

    // line level select from the transmit FSM to the shifter
    localparam logic [1:0] LSEL_IDLE  = 2'd0;
    localparam logic [1:0] LSEL_START = 2'd1;
    localparam logic [1:0] LSEL_DATA  = 2'd2;
    localparam logic [1:0] LSEL_STOP  = 2'd3;

    // one received byte as handed to the user
    typedef struct packed {
        byte_t data;
        logic  frame_err;  // stop bit was sampled low
    } rx_byte_s;

endpackage

// ==== hw/rx_deframer.sv ====
`timescale 1ns/1ns

module rx_deframer #(
    parameter timing_pkg::tick_cnt_t BIT_CLKS = 8'd8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sdi,
    output link_pkg::rx_byte_s out_byte,
    output logic               out_valid
);
    localparam timing_pkg::bit_idx_t LAST_DATA =
        timing_pkg::bit_idx_t'($bits(link_pkg::byte_t) - 1);

    logic                  sync_meta;
    logic                  line;       // sdi after the two flops
    logic                  line_prev;
    logic                  start_edge;
    logic                  tick;
    timing_pkg::rx_state_e state;
    timing_pkg::bit_idx_t  bit_idx;
    link_pkg::byte_t       shreg;
    link_pkg::byte_t       data_q;
    logic                  err_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_meta <= link_pkg::LINE_IDLE;
            line      <= link_pkg::LINE_IDLE;
            line_prev <= link_pkg::LINE_IDLE;
        end else begin
            sync_meta <= sdi;
            line      <= sync_meta;
            line_prev <= line;
        end
    end

    // only a falling edge counts as a start, so a line stuck low after a
    // framing error has to go high before the next frame is looked for
    assign start_edge = (state == timing_pkg::RX_IDLE)
                     && (line != link_pkg::LINE_IDLE)
                     && (line_prev == link_pkg::LINE_IDLE);

    // half period load puts every tick at the middle of a bit
    bit_timer #(
        .BIT_CLKS(BIT_CLKS)
    ) timer_i (
        .clk    (clk),
        .rst    (rst),
        .restart(start_edge),
        .half   (1'b1),
        .tick   (tick)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // deframing FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= timing_pkg::RX_IDLE;
            bit_idx   <= '0;
            err_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
            timing_pkg::RX_IDLE: begin
                if (start_edge) state <= timing_pkg::RX_START_CHK;
            end
            timing_pkg::RX_START_CHK: begin
                if (tick) begin
                    bit_idx <= '0;
                    // line back high by mid-bit means it was only a glitch
                    state <= (line == link_pkg::LINE_IDLE) ? timing_pkg::RX_IDLE
                                                           : timing_pkg::RX_DATA;
                end
            end
            timing_pkg::RX_DATA: begin
                if (tick) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == LAST_DATA) state <= timing_pkg::RX_STOP;
                end
            end
            timing_pkg::RX_STOP: begin
                if (tick) begin
                    out_valid <= 1'b1;
                    err_q     <= (line != link_pkg::LINE_IDLE);  // stop bit must be high
                    state     <= timing_pkg::RX_IDLE;
                end
            end
            default: state <= timing_pkg::RX_IDLE;
            endcase
        end
    end

    // data arrives msb first, so it shifts in from the bottom
    always_ff @(posedge clk) begin
        if (state == timing_pkg::RX_DATA && tick) begin
            shreg <= {shreg[6:0], line};
        end
        if (state == timing_pkg::RX_STOP && tick) begin
            data_q <= shreg;
        end
    end

    assign out_byte = '{data: data_q, frame_err: err_q};

endmodule

// ==== hw/serial_link_top.sv ====
`timescale 1ns/1ns

module serial_link_top #(
    parameter timing_pkg::tick_cnt_t BIT_CLKS = 8'd8
) (
    input  logic               clk,
    input  logic               rst,
    input  link_pkg::byte_t    in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output logic               sdo,
    input  logic               sdi,
    output link_pkg::rx_byte_s out_byte,
    output logic               out_valid
);
    logic       load;
    logic       shift;
    logic [1:0] line_sel;

    // transmit path
    tx_fsm #(
        .BIT_CLKS(BIT_CLKS)
    ) tx_fsm_i (
        .clk     (clk),
        .rst     (rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .load    (load),
        .shift   (shift),
        .line_sel(line_sel)
    );

    tx_shift tx_shift_i (
        .clk     (clk),
        .rst     (rst),
        .in_data (in_data),
        .load    (load),
        .shift   (shift),
        .line_sel(line_sel),
        .sdo     (sdo)
    );

    // receive path, fully independent of the transmitter
    rx_deframer #(
        .BIT_CLKS(BIT_CLKS)
    ) rx_deframer_i (
        .clk      (clk),
        .rst      (rst),
        .sdi      (sdi),
        .out_byte (out_byte),
        .out_valid(out_valid)
    );

endmodule

// ==== hw/timing_pkg.sv ====
package timing_pkg;

    // cycles inside one bit period, so periods up to 256 clocks fit
    typedef logic [7:0] tick_cnt_t;

    // position of the current bit inside a frame
    typedef logic [3:0] bit_idx_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START_CHK,  // wait for mid start bit and look again
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// ==== hw/tx_fsm.sv ====
`timescale 1ns/1ns

module tx_fsm #(
    parameter timing_pkg::tick_cnt_t BIT_CLKS = 8'd8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       load,
    output logic       shift,
    output logic [1:0] line_sel
);
    // index of the last data bit, counting the start bit as zero
    localparam timing_pkg::bit_idx_t LAST_DATA =
        timing_pkg::bit_idx_t'(link_pkg::FRAME_BITS - 2);

    timing_pkg::tx_state_e state;
    timing_pkg::tx_state_e state_nxt;
    timing_pkg::bit_idx_t  bit_idx;
    logic                  accept;
    logic                  tick;

    assign accept = in_valid && in_ready;  // in_ready is only high in idle
    assign load   = accept;
    assign shift  = (state == timing_pkg::TX_DATA) && tick;

    // the timer starts over with each accepted byte so bit edges line up
    bit_timer #(
        .BIT_CLKS(BIT_CLKS)
    ) timer_i (
        .clk    (clk),
        .rst    (rst),
        .restart(accept),
        .half   (1'b0),
        .tick   (tick)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
        timing_pkg::TX_IDLE:  if (accept) state_nxt = timing_pkg::TX_START;
        timing_pkg::TX_START: if (tick) state_nxt = timing_pkg::TX_DATA;
        timing_pkg::TX_DATA:  if (tick && bit_idx == LAST_DATA) state_nxt = timing_pkg::TX_STOP;
        timing_pkg::TX_STOP:  if (tick) state_nxt = timing_pkg::TX_IDLE;
        default:              state_nxt = timing_pkg::TX_IDLE;
        endcase
    end

    // the shifter registers the level, so it follows the next state
    always_comb begin
        case (state_nxt)
        timing_pkg::TX_START: line_sel = link_pkg::LSEL_START;
        timing_pkg::TX_DATA:  line_sel = link_pkg::LSEL_DATA;
        timing_pkg::TX_STOP:  line_sel = link_pkg::LSEL_STOP;
        default:              line_sel = link_pkg::LSEL_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= timing_pkg::TX_IDLE;
            bit_idx  <= '0;
            in_ready <= 1'b0;
        end else begin
            state    <= state_nxt;
            in_ready <= (state_nxt == timing_pkg::TX_IDLE);  // high again with the idle line
            if (accept) begin
                bit_idx <= '0;
            end else if (tick && state != timing_pkg::TX_IDLE) begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

endmodule

// ==== hw/tx_shift.sv ====
`timescale 1ns/1ns

module tx_shift (
    input  logic            clk,
    input  logic            rst,
    input  link_pkg::byte_t in_data,
    input  logic            load,
    input  logic            shift,
    input  logic [1:0]      line_sel,
    output logic            sdo
);
    link_pkg::byte_t buff;
    link_pkg::byte_t buff_nxt;
    logic            level;

    // the data level is taken after this cycle's shift, so the new bit
    // reaches the line together with the tick that asked for it
    assign buff_nxt = shift ? {buff[6:0], 1'b0} : buff;

    always_ff @(posedge clk) begin
        if (load) begin
            buff <= in_data;
        end else begin
            buff <= buff_nxt;
        end
    end

    always_comb begin
        case (line_sel)
        link_pkg::LSEL_START: level = ~link_pkg::LINE_IDLE;
        link_pkg::LSEL_DATA:  level = buff_nxt[7];  // msb goes out first
        link_pkg::LSEL_STOP:  level = link_pkg::LINE_IDLE;
        default:              level = link_pkg::LINE_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdo <= link_pkg::LINE_IDLE;
        end else begin
            sdo <= level;  // registered so the line never glitches
        end
    end

endmodule

// ==== serial_link_top.f ====
hw/link_pkg.sv
hw/timing_pkg.sv
hw/bit_timer.sv
hw/tx_fsm.sv
hw/tx_shift.sv
hw/rx_deframer.sv
hw/serial_link_top.sv
verification/serial_link_assert.sv
verification/serial_link_tb.sv

// ==== verification/serial_link_assert.sv ====
`timescale 1ns/1ns

module serial_link_assert (
    input logic                  clk,
    input logic                  rst,
    input link_pkg::byte_t       in_data,
    input logic                  in_valid,
    input logic                  in_ready,
    input logic                  sdo,
    input logic                  out_valid,
    input timing_pkg::tx_state_e tx_state
);
    int fail_count = 0;  // read by the testbench for its verdict

    // the transmitter only takes a byte while it has nothing to send
    ready_only_idle: assert property (@(posedge clk) disable iff (rst)
        tx_state != timing_pkg::TX_IDLE |-> !in_ready)
        else begin
            $error("in_ready is high while the transmit FSM is busy");
            fail_count++;
        end

    single_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid lasted more than one cycle");
            fail_count++;
        end

    idle_line_high: assert property (@(posedge clk) disable iff (rst)
        tx_state == timing_pkg::TX_IDLE |-> sdo == link_pkg::LINE_IDLE)
        else begin
            $error("sdo is low while the transmit FSM is idle");
            fail_count++;
        end

    // a waiting byte must be held until it is taken
    data_held: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin
            $error("in_data or in_valid changed before the byte was accepted");
            fail_count++;
        end

endmodule

bind serial_link_top serial_link_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .sdo      (sdo),
    .out_valid(out_valid),
    .tx_state (tx_fsm_i.state)
);

// ==== verification/serial_link_tb.sv ====
`timescale 1ns/1ns

module serial_link_tb;

    localparam int BIT_CLKS    = 8;  // the DUT runs with its default bit period
    localparam int FRAME_CLKS  = link_pkg::FRAME_BITS * BIT_CLKS;
    localparam int RESET_CLKS  = 8;
    localparam int N_LOOP      = 64;
    localparam int N_FORMAT    = 16;
    localparam int N_PRESSURE  = 32;
    localparam int N_ERR_RND   = 4;  // one bad frame and two good ones per round
    localparam int N_GLITCH    = 8;
    localparam int N_FRAMES    = N_LOOP + N_FORMAT + N_PRESSURE + 3 * N_ERR_RND + N_GLITCH;
    localparam int GLITCH_CLKS = N_GLITCH * (BIT_CLKS / 2 + BIT_CLKS);
    localparam int LIMIT       = (N_FRAMES * FRAME_CLKS + GLITCH_CLKS) * 2 + RESET_CLKS;

    logic               clk = 1'b0;
    logic               rst;
    link_pkg::byte_t    in_data;
    logic               in_valid;
    logic               in_ready;
    logic               sdo;
    logic               sdi;
    link_pkg::rx_byte_s out_byte;
    logic               out_valid;

    logic               loop_mode;  // sdi follows sdo when set
    logic               inj_line;
    logic               mon_on;
    logic [31:0]        lfsr;
    int                 cycles = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 accepts = 0;
    int                 valids = 0;
    int                 busy = 0;   // cycles left in the frame being sent
    link_pkg::rx_byte_s rx_exp[$];
    logic               line_exp[$];

    assign sdi = loop_mode ? sdo : inj_line;

    serial_link_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .sdo      (sdo),
        .sdi      (sdi),
        .out_byte (out_byte),
        .out_valid(out_valid)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // start bit low, data msb first, then the stop bit
    function automatic logic frame_level(input link_pkg::byte_t b, input int k,
                                         input logic stop_ok);
        if (k == 0) return 1'b0;
        if (k == link_pkg::FRAME_BITS - 1) return stop_ok;
        return b[8 - k];
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic check_count(input string what, input int got, input int want);
        checks++;
        if (got != want) begin
            report_fail($sformatf("%s is %0d, expected %0d", what, got, want));
        end
    endtask

    // offer one byte after an idle gap and hold it until it is taken
    task automatic offer_byte(input link_pkg::byte_t b, input int gap);
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_data  <= b;
        in_valid <= 1'b1;
        do @(posedge clk); while (!in_ready);
    endtask

    task automatic send_frame(input link_pkg::byte_t b, input logic stop_ok);
        rx_exp.push_back(link_pkg::rx_byte_s'{data: b, frame_err: !stop_ok});
        for (int k = 0; k < link_pkg::FRAME_BITS; k++) begin
            inj_line <= frame_level(b, k, stop_ok);
            repeat (BIT_CLKS) @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);  // the model has taken in a byte accepted on the last edge
        while (rx_exp.size() > 0 || line_exp.size() > 0 || busy > 0) begin
            @(posedge clk);
        end
        repeat (2 * BIT_CLKS) @(posedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // line and receive model
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        logic               exp;
        link_pkg::rx_byte_s want;
        if (mon_on) begin
            exp = (line_exp.size() > 0) ? line_exp.pop_front() : link_pkg::LINE_IDLE;
            checks += 2;
            if (sdo !== exp) begin
                report_fail($sformatf("sdo is %b, expected %b", sdo, exp));
            end
            if (in_ready !== (busy == 0)) begin
                report_fail($sformatf("in_ready is %b, expected %b", in_ready, busy == 0));
            end
            if (out_valid === 1'b1) begin
                valids++;
                checks++;
                if (rx_exp.size() == 0) begin
                    report_fail($sformatf("out_valid with data %h, none expected",
                                          out_byte.data));
                end else begin
                    want = rx_exp.pop_front();
                    if (out_byte !== want) begin
                        report_fail($sformatf("received %h err %b, expected %h err %b",
                                              out_byte.data, out_byte.frame_err,
                                              want.data, want.frame_err));
                    end
                end
            end
            if (in_valid && in_ready) begin
                accepts++;
                busy = FRAME_CLKS;  // the next frame may start right after the stop bit
                for (int k = 0; k < link_pkg::FRAME_BITS; k++) begin
                    repeat (BIT_CLKS) line_exp.push_back(frame_level(in_data, k, 1'b1));
                end
                if (loop_mode) begin
                    rx_exp.push_back(link_pkg::rx_byte_s'{data: in_data, frame_err: 1'b0});
                end
            end else if (busy > 0) begin
                busy--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int err_mark;
        int acc_mark;
        int val_mark;
        int width;
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        loop_mode = 1'b1;
        inj_line  = link_pkg::LINE_IDLE;
        mon_on    = 1'b0;
        lfsr      = 32'h73f2_de5a;

        repeat (RESET_CLKS) @(posedge clk);
        checks++;
        if (sdo !== link_pkg::LINE_IDLE || in_ready !== 1'b0 || out_valid !== 1'b0
                || out_byte.frame_err !== 1'b0) begin
            report_fail("sdo, in_ready, out_valid or frame_err wrong during reset");
        end
        rst <= 1'b0;
        @(posedge clk);
        checks++;
        if (in_ready !== 1'b0) begin
            report_fail("in_ready high before the first clock after reset");
        end
        mon_on <= 1'b1;

        err_mark = errors;
        acc_mark = accepts;
        val_mark = valids;
        for (int i = 0; i < N_LOOP; i++) begin
            offer_byte(link_pkg::byte_t'(rand_bits(8)), 0);
        end
        in_valid <= 1'b0;
        wait_drain();
        check_count("accepted bytes", accepts - acc_mark, N_LOOP);
        check_count("out_valid pulses", valids - val_mark, N_LOOP);
        $display("test 1 loopback data: %0d errors", errors - err_mark);

        err_mark = errors;
        for (int i = 0; i < N_FORMAT; i++) begin
            offer_byte(link_pkg::byte_t'(rand_bits(8)), int'(rand_bits(4)));
        end
        in_valid <= 1'b0;
        wait_drain();
        $display("test 2 line format and timing: %0d errors", errors - err_mark);

        // gaps up to 127 cycles, so some bytes wait on a busy transmitter
        // and others find it idle
        err_mark = errors;
        acc_mark = accepts;
        val_mark = valids;
        for (int i = 0; i < N_PRESSURE; i++) begin
            offer_byte(link_pkg::byte_t'(rand_bits(8)), int'(rand_bits(7)));
        end
        in_valid <= 1'b0;
        wait_drain();
        check_count("accepted bytes", accepts - acc_mark, N_PRESSURE);
        check_count("out_valid pulses", valids - val_mark, N_PRESSURE);
        $display("test 3 back-pressure: %0d errors", errors - err_mark);

        loop_mode <= 1'b0;
        @(posedge clk);
        err_mark = errors;
        val_mark = valids;
        for (int r = 0; r < N_ERR_RND; r++) begin
            send_frame(link_pkg::byte_t'(rand_bits(8)), 1'b0);
            inj_line <= link_pkg::LINE_IDLE;  // line must rise before the next start
            repeat (BIT_CLKS) @(posedge clk);
            send_frame(link_pkg::byte_t'(rand_bits(8)), 1'b1);
            send_frame(link_pkg::byte_t'(rand_bits(8)), 1'b1);
        end
        wait_drain();
        check_count("out_valid pulses", valids - val_mark, 3 * N_ERR_RND);
        $display("test 4 framing error: %0d errors", errors - err_mark);

        // pulses stay below half a bit, so the mid-bit check sees the line high
        err_mark = errors;
        for (int g = 0; g < N_GLITCH; g++) begin
            val_mark = valids;
            width    = 1 + int'(rand_bits(8)) % (BIT_CLKS / 2 - 1);
            inj_line <= 1'b0;
            repeat (width) @(posedge clk);
            inj_line <= link_pkg::LINE_IDLE;
            repeat (BIT_CLKS) @(posedge clk);
            send_frame(link_pkg::byte_t'(rand_bits(8)), 1'b1);
            wait_drain();
            check_count("out_valid pulses after a glitch and a frame", valids - val_mark, 1);
        end
        $display("test 5 glitch rejection: %0d errors", errors - err_mark);

        errors += dut_i.assert_i.fail_count;
        $display("summary: %0d checks, %0d errors, %0d accepted, %0d received",
                 checks, errors, accepts, valids);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
